//--- vga_pkg.sv
`default_nettype none

package vga_pkg;

	// byte address on the memory bus
	typedef logic [25:0] addr_t;

	// one pixel per bus word, upper byte unused
	typedef logic [31:0] pixel_word_t;

	// lane index carried with each read in flight, up to 16 lanes
	typedef logic [3:0] lane_tag_t;

	// address step between consecutive pixel words
	localparam addr_t WORD_BYTES = 26'd4;

	// colour field layout inside a pixel word
	localparam int COLOR_W = 8;
	localparam int RED_LSB = 0;
	localparam int GREEN_LSB = 8;
	localparam int BLUE_LSB = 16;

endpackage

`default_nettype wire

//--- pixel_lane_if.sv
`timescale 1ns/100ps
`default_nettype none

interface pixel_lane_if;

	logic reserve;
	logic can_reserve;
	logic push;
	vga_pkg::pixel_word_t push_data;
	logic pop;
	vga_pkg::pixel_word_t head;
	logic empty;

	// bus read master side
	modport fetch (
		output reserve,
		output push,
		output push_data,
		input can_reserve
	);

	// the prefetch buffer itself
	modport lane (
		input reserve,
		input push,
		input push_data,
		input pop,
		output can_reserve,
		output head,
		output empty
	);

	// pixel consumer
	modport scan (
		output pop,
		input head,
		input empty
	);

endinterface

`default_nettype wire

//--- sync_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
	parameter int DEPTH = 4,
	parameter type payload_t = logic [31:0]
) (
	input wire clk,
	input wire reset,
	input wire wr,
	input wire payload_t wdata,
	input wire rd,
	output payload_t rdata,
	output logic empty,
	output logic [$clog2(DEPTH + 1)-1:0] count
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;

	// pointers wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[wr_ptr] <= wdata;
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (rd) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({wr, rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// head word is visible without a read strobe
	assign rdata = mem[rd_ptr];
	assign empty = (count == '0);

endmodule

`default_nettype wire

//--- pixel_lane.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_lane #(
	parameter int LANE_DEPTH = 4
) (
	input wire clk,
	input wire reset,
	pixel_lane_if.lane lane
);

	localparam int CNT_W = $clog2(LANE_DEPTH + 1);

	logic [CNT_W-1:0] fifo_count;
	logic [CNT_W-1:0] reserved;
	logic [CNT_W:0] committed;

	sync_fifo #(
		.DEPTH(LANE_DEPTH),
		.payload_t(vga_pkg::pixel_word_t)
	) u_fifo (
		.clk(clk),
		.reset(reset),
		.wr(lane.push),
		.wdata(lane.push_data),
		.rd(lane.pop),
		.rdata(lane.head),
		.empty(lane.empty),
		.count(fifo_count)
	);

	// slots promised to reads still on the bus
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			reserved <= '0;
		end else begin
			case ({lane.reserve, lane.push})
				2'b10: reserved <= reserved + 1'b1;
				2'b01: reserved <= reserved - 1'b1;
				default: reserved <= reserved;
			endcase
		end
	end

	// stored plus promised words bound the fifo, whatever the latency
	assign committed = {1'b0, fifo_count} + {1'b0, reserved};
	assign lane.can_reserve = committed < (CNT_W + 1)'(LANE_DEPTH);

endmodule

`default_nettype wire

//--- frame_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module frame_fetch #(
	parameter int NUM_LANES = 4,
	parameter int LANE_DEPTH = 4,
	parameter int FRAME_WORDS = 640 * 480
) (
	input wire clk,
	input wire reset,
	input wire vga_pkg::addr_t base,
	output vga_pkg::addr_t avm_address,
	output logic avm_read,
	input wire avm_waitrequest,
	input wire vga_pkg::pixel_word_t avm_readdata,
	input wire avm_readdatavalid,
	pixel_lane_if.fetch lanes [NUM_LANES]
);

	localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
	localparam int WORD_W = (FRAME_WORDS > 1) ? $clog2(FRAME_WORDS) : 1;
	localparam int TAG_DEPTH = NUM_LANES * LANE_DEPTH;
	localparam int TAG_CNT_W = $clog2(TAG_DEPTH + 1);

	logic [WORD_W-1:0] word_idx;
	vga_pkg::addr_t byte_off;
	logic [LANE_W-1:0] lane_idx;
	logic [LANE_W-1:0] next_lane;
	logic [NUM_LANES-1:0] lane_can;
	logic accept;
	logic tag_room;
	logic can_issue;
	vga_pkg::lane_tag_t tag_head;
	logic tag_empty;
	logic [TAG_CNT_W-1:0] tag_count;
	logic data_ok;
	logic [7:0] rd_fault_count;

	assign accept = avm_read && !avm_waitrequest;
	assign data_ok = avm_readdatavalid && !tag_empty;
	assign next_lane = (lane_idx == LANE_W'(NUM_LANES - 1)) ? '0 : lane_idx + 1'b1;

	// tags of reads in flight, in issue order
	sync_fifo #(
		.DEPTH(TAG_DEPTH),
		.payload_t(vga_pkg::lane_tag_t)
	) u_tag_fifo (
		.clk(clk),
		.reset(reset),
		.wr(accept),
		.wdata(vga_pkg::lane_tag_t'(lane_idx)),
		.rd(data_ok),
		.rdata(tag_head),
		.empty(tag_empty),
		.count(tag_count)
	);

	for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
		assign lane_can[g] = lanes[g].can_reserve;
		assign lanes[g].reserve = accept && (lane_idx == LANE_W'(g));
		assign lanes[g].push = data_ok && (tag_head == vga_pkg::lane_tag_t'(g));
		assign lanes[g].push_data = avm_readdata;
	end

	// count an accepted read that lands now toward the tag limit
	assign tag_room = ({1'b0, tag_count} + {{TAG_CNT_W{1'b0}}, accept})
		< (TAG_CNT_W + 1)'(TAG_DEPTH);

	// a lane reserved this cycle cannot be trusted again until next cycle
	always_comb begin
		if (accept) begin
			can_issue = lane_can[next_lane] && (next_lane != lane_idx) && tag_room;
		end else begin
			can_issue = lane_can[lane_idx] && tag_room;
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			avm_read <= 1'b0;
			word_idx <= '0;
			byte_off <= '0;
			lane_idx <= '0;
		end else begin
			if (accept) begin
				lane_idx <= next_lane;
				if (word_idx == WORD_W'(FRAME_WORDS - 1)) begin
					word_idx <= '0;
					byte_off <= '0;
				end else begin
					word_idx <= word_idx + 1'b1;
					byte_off <= byte_off + vga_pkg::WORD_BYTES;
				end
			end
			// request stays up untouched while the slave stalls
			if (!avm_read || accept) begin
				avm_read <= can_issue;
			end
		end
	end

	assign avm_address = base + byte_off;

	// data with no read outstanding is a slave fault
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			rd_fault_count <= '0;
		end else if (avm_readdatavalid && tag_empty && (rd_fault_count != 8'hff)) begin
			rd_fault_count <= rd_fault_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- scanout.sv
`timescale 1ns/100ps
`default_nettype none

module scanout #(
	parameter int NUM_LANES = 4,
	parameter int PIX_DIV = 2,
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33
) (
	input wire clk,
	input wire reset,
	pixel_lane_if.scan lanes [NUM_LANES],
	output logic [vga_pkg::COLOR_W-1:0] vga_r,
	output logic [vga_pkg::COLOR_W-1:0] vga_g,
	output logic [vga_pkg::COLOR_W-1:0] vga_b,
	output logic vga_hs,
	output logic vga_vs,
	output logic vga_blank_n,
	output logic vga_pix_ce,
	output logic underrun
);

	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int HC_W = $clog2(H_TOTAL);
	localparam int VC_W = $clog2(V_TOTAL);
	localparam int DIV_W = (PIX_DIV > 1) ? $clog2(PIX_DIV) : 1;
	localparam int RR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

	logic [DIV_W-1:0] div_cnt;
	logic tick;
	logic [HC_W-1:0] hcount;
	logic [VC_W-1:0] vcount;
	logic [RR_W-1:0] rr;
	logic active;
	logic hs_zone;
	logic vs_zone;
	logic pop_now;
	vga_pkg::pixel_word_t lane_head [NUM_LANES];
	logic [NUM_LANES-1:0] lane_empty;

	assign tick = (div_cnt == DIV_W'(PIX_DIV - 1));

	for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
		assign lane_head[g] = lanes[g].head;
		assign lane_empty[g] = lanes[g].empty;
		assign lanes[g].pop = pop_now && (rr == RR_W'(g));
	end

	// position decode, counters start at the first active pixel
	assign active = (hcount < HC_W'(H_ACTIVE)) && (vcount < VC_W'(V_ACTIVE));
	assign hs_zone = (hcount >= HC_W'(H_ACTIVE + H_FRONT))
		&& (hcount < HC_W'(H_ACTIVE + H_FRONT + H_SYNC));
	assign vs_zone = (vcount >= VC_W'(V_ACTIVE + V_FRONT))
		&& (vcount < VC_W'(V_ACTIVE + V_FRONT + V_SYNC));

	// an empty lane is skipped, not consumed
	assign pop_now = tick && active && !lane_empty[rr];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			div_cnt <= '0;
			hcount <= '0;
			vcount <= '0;
			rr <= '0;
		end else begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			if (tick) begin
				if (hcount == HC_W'(H_TOTAL - 1)) begin
					hcount <= '0;
					vcount <= (vcount == VC_W'(V_TOTAL - 1)) ? '0 : vcount + 1'b1;
				end else begin
					hcount <= hcount + 1'b1;
				end
			end
			if (pop_now) begin
				rr <= (rr == RR_W'(NUM_LANES - 1)) ? '0 : rr + 1'b1;
			end
		end
	end

	// registered pixel outputs, one cycle behind the tick
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
			vga_hs <= 1'b1;
			vga_vs <= 1'b1;
			vga_blank_n <= 1'b0;
			vga_pix_ce <= 1'b0;
			underrun <= 1'b0;
		end else begin
			vga_pix_ce <= tick;
			if (tick) begin
				vga_hs <= !hs_zone;
				vga_vs <= !vs_zone;
				vga_blank_n <= active;
				if (pop_now) begin
					vga_r <= lane_head[rr][vga_pkg::RED_LSB +: vga_pkg::COLOR_W];
					vga_g <= lane_head[rr][vga_pkg::GREEN_LSB +: vga_pkg::COLOR_W];
					vga_b <= lane_head[rr][vga_pkg::BLUE_LSB +: vga_pkg::COLOR_W];
				end else begin
					vga_r <= '0;
					vga_g <= '0;
					vga_b <= '0;
				end
				// sticky once any active pixel finds its lane dry
				if (active && lane_empty[rr]) begin
					underrun <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- vga_frame_top.sv
`timescale 1ns/100ps
`default_nettype none

module vga_frame_top #(
	parameter int NUM_LANES = 4,
	parameter int LANE_DEPTH = 4,
	parameter int PIX_DIV = 2,
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33,
	parameter int FRAME_WORDS = H_ACTIVE * V_ACTIVE
) (
	input wire clk,
	input wire reset,
	input wire vga_pkg::addr_t base,
	output vga_pkg::addr_t avm_address,
	output logic avm_read,
	input wire avm_waitrequest,
	input wire vga_pkg::pixel_word_t avm_readdata,
	input wire avm_readdatavalid,
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b,
	output logic vga_hs,
	output logic vga_vs,
	output logic vga_blank_n,
	output logic vga_pix_ce,
	output logic underrun
);

	pixel_lane_if lane_bus [NUM_LANES] ();

	frame_fetch #(
		.NUM_LANES(NUM_LANES),
		.LANE_DEPTH(LANE_DEPTH),
		.FRAME_WORDS(FRAME_WORDS)
	) u_fetch (
		.clk(clk),
		.reset(reset),
		.base(base),
		.avm_address(avm_address),
		.avm_read(avm_read),
		.avm_waitrequest(avm_waitrequest),
		.avm_readdata(avm_readdata),
		.avm_readdatavalid(avm_readdatavalid),
		.lanes(lane_bus)
	);

	// word i of the frame lives in lane i mod NUM_LANES
	for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
		pixel_lane #(
			.LANE_DEPTH(LANE_DEPTH)
		) u_lane (
			.clk(clk),
			.reset(reset),
			.lane(lane_bus[g])
		);
	end

	scanout #(
		.NUM_LANES(NUM_LANES),
		.PIX_DIV(PIX_DIV),
		.H_ACTIVE(H_ACTIVE),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK)
	) u_scan (
		.clk(clk),
		.reset(reset),
		.lanes(lane_bus),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs),
		.vga_blank_n(vga_blank_n),
		.vga_pix_ce(vga_pix_ce),
		.underrun(underrun)
	);

endmodule

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 4,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// release lands just after a rising edge, like every other input
	initial begin
		reset = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b1;
	end

endmodule

`default_nettype wire

//--- tb_vga_assert.sv
`timescale 1ns/100ps
`default_nettype none

module tb_vga_assert #(
	parameter int NUM_LANES = 4,
	parameter int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
	input wire clk,
	input wire reset,
	input wire vga_pkg::addr_t avm_address,
	input wire avm_read,
	input wire avm_waitrequest,
	input wire [7:0] rd_fault_count,
	input wire [NUM_LANES-1:0] lane_can,
	input wire [LANE_W-1:0] lane_idx
);

	// a stalled request must not move
	assert property (@(posedge clk) disable iff (!reset)
		(avm_read && avm_waitrequest) |=> (avm_read && $stable(avm_address)))
		else $error("read request changed while waitrequest was high");

	// every returned word needs a read in flight
	assert property (@(posedge clk) disable iff (!reset)
		rd_fault_count == 8'd0)
		else $error("readdatavalid arrived with no read outstanding");

	// an accepted read reserves a slot in its lane
	assert property (@(posedge clk) disable iff (!reset)
		(avm_read && !avm_waitrequest) |-> lane_can[lane_idx])
		else $error("read accepted for a lane with no free slot");

endmodule

bind frame_fetch tb_vga_assert #(
	.NUM_LANES(NUM_LANES)
) u_assert (
	.clk(clk),
	.reset(reset),
	.avm_address(avm_address),
	.avm_read(avm_read),
	.avm_waitrequest(avm_waitrequest),
	.rd_fault_count(rd_fault_count),
	.lane_can(lane_can),
	.lane_idx(lane_idx)
);

`default_nettype wire

//--- tb_vga_frame.sv
`timescale 1ns/100ps
`default_nettype none

module tb_vga_frame;

	localparam int NUM_LANES = 4;
	localparam int LANE_DEPTH = 4;
	localparam int PIX_DIV = 2;
	localparam int H_ACTIVE = 16;
	localparam int H_FRONT = 2;
	localparam int H_SYNC = 3;
	localparam int H_BACK = 2;
	localparam int V_ACTIVE = 6;
	localparam int V_FRONT = 1;
	localparam int V_SYNC = 1;
	localparam int V_BACK = 1;
	localparam int FRAME_WORDS = H_ACTIVE * V_ACTIVE;
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int FRAME_LIMIT = 2 * H_TOTAL * V_TOTAL * PIX_DIV;
	localparam vga_pkg::addr_t BASE = 26'h012_3400;
	// syncs high, blanked, black, no underrun
	localparam logic [31:0] IDLE_BITS = 32'h0000_0006;

	logic clk;
	logic reset;
	vga_pkg::addr_t base;
	vga_pkg::addr_t avm_address;
	logic avm_read;
	logic avm_waitrequest;
	vga_pkg::pixel_word_t avm_readdata;
	logic avm_readdatavalid;
	logic [7:0] vga_r;
	logic [7:0] vga_g;
	logic [7:0] vga_b;
	logic vga_hs;
	logic vga_vs;
	logic vga_blank_n;
	logic vga_pix_ce;
	logic underrun;

	// memory model
	logic [31:0] rng;
	int ret_q [$];
	vga_pkg::addr_t addr_q [$];
	int last_ret;
	int accepted;
	bit stall;

	// scan-out model
	int cyc;
	int delivered;
	int consumed;
	int starved;
	int hpos;
	int vpos;
	int frames_done;
	int last_strobe_cyc;
	bit seen_strobe;
	bit exp_underrun;
	logic [31:0] held_bits;
	int checks;
	int errors;

	tb_clock #(
		.PERIOD(4),
		.RESET_CYCLES(10)
	) u_clock (
		.clk(clk),
		.reset(reset)
	);

	vga_frame_top #(
		.NUM_LANES(NUM_LANES),
		.LANE_DEPTH(LANE_DEPTH),
		.PIX_DIV(PIX_DIV),
		.H_ACTIVE(H_ACTIVE),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK),
		.FRAME_WORDS(FRAME_WORDS)
	) u_dut (
		.clk(clk),
		.reset(reset),
		.base(base),
		.avm_address(avm_address),
		.avm_read(avm_read),
		.avm_waitrequest(avm_waitrequest),
		.avm_readdata(avm_readdata),
		.avm_readdatavalid(avm_readdatavalid),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs),
		.vga_blank_n(vga_blank_n),
		.vga_pix_ce(vga_pix_ce),
		.underrun(underrun)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// frame memory contents, stirred from every address bit
	function automatic vga_pkg::pixel_word_t mem_word(input vga_pkg::addr_t a);
		logic [31:0] x;
		x = {6'd0, a} ^ 32'h9e37_79b9;
		x = x ^ (x << 7);
		x = x ^ (x >> 11);
		x = x * 32'h2c1b_3c6d;
		x = x ^ (x >> 15);
		return x;
	endfunction

	function automatic vga_pkg::addr_t word_addr(input int n);
		return BASE + vga_pkg::addr_t'(n % FRAME_WORDS) * vga_pkg::WORD_BYTES;
	endfunction

	function automatic logic [31:0] out_bits();
		return 32'({underrun, vga_r, vga_g, vga_b, vga_hs, vga_vs, vga_blank_n});
	endfunction

	function automatic bit sync_level(input int pos, input int start, input int len);
		return !(pos >= start && pos < start + len);
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("Mismatch at %0t: %s expected %h, got %h", $time, what, expected, actual);
		end
	endtask

	task automatic check_scanout();
		vga_pkg::pixel_word_t w;
		bit active;
		if (vga_pix_ce) begin
			if (seen_strobe) begin
				check_value("strobe spacing", PIX_DIV, cyc - last_strobe_cyc);
			end
			seen_strobe = 1'b1;
			last_strobe_cyc = cyc;
			active = (hpos < H_ACTIVE) && (vpos < V_ACTIVE);
			check_value("blank_n", 32'(active), 32'(vga_blank_n));
			check_value("hsync", 32'(sync_level(hpos, H_ACTIVE + H_FRONT, H_SYNC)), 32'(vga_hs));
			check_value("vsync", 32'(sync_level(vpos, V_ACTIVE + V_FRONT, V_SYNC)), 32'(vga_vs));
			// next word is shown only if it reached its lane before the tick
			if (active && consumed < delivered) begin
				w = mem_word(word_addr(consumed));
				check_value("red", 32'(w[7:0]), 32'(vga_r));
				check_value("green", 32'(w[15:8]), 32'(vga_g));
				check_value("blue", 32'(w[23:16]), 32'(vga_b));
				consumed++;
			end else begin
				check_value("black rgb", 32'd0, 32'({vga_r, vga_g, vga_b}));
				if (active) begin
					starved++;
					exp_underrun = 1'b1;
				end
			end
			check_value("underrun", 32'(exp_underrun), 32'(underrun));
			held_bits = out_bits();
			if (hpos == H_TOTAL - 1) begin
				hpos = 0;
				if (vpos == V_TOTAL - 1) begin
					vpos = 0;
					frames_done++;
				end else begin
					vpos++;
				end
			end else begin
				hpos++;
			end
		end else if (seen_strobe) begin
			check_value("held outputs", held_bits, out_bits());
		end else begin
			check_value("outputs before first strobe", IDLE_BITS, out_bits());
		end
	endtask

	task automatic drive_memory();
		int lat;
		int ret;
		avm_readdatavalid = 1'b0;
		avm_readdata = '0;
		// oldest read returns at the coming edge
		if (ret_q.size() > 0 && ret_q[0] == cyc + 1) begin
			avm_readdatavalid = 1'b1;
			avm_readdata = mem_word(addr_q[0]);
			void'(ret_q.pop_front());
			void'(addr_q.pop_front());
		end
		rng = xorshift32(rng);
		avm_waitrequest = stall || (rng[1:0] == 2'd0);
		if (avm_read && !avm_waitrequest) begin
			check_value("read address", 32'(word_addr(accepted)), 32'(avm_address));
			rng = xorshift32(rng);
			lat = 1 + int'(rng % 32'd6);
			ret = cyc + 1 + lat;
			// returns stay in order, one per cycle at most
			if (ret <= last_ret) begin
				ret = last_ret + 1;
			end
			last_ret = ret;
			ret_q.push_back(ret);
			addr_q.push_back(avm_address);
			accepted++;
		end
	endtask

	task automatic run_cycle();
		bit pushed;
		@(posedge clk);
		#1;
		cyc++;
		// a push at this edge is too late for this strobe
		pushed = avm_readdatavalid;
		check_scanout();
		if (pushed) begin
			delivered++;
		end
		drive_memory();
	endtask

	task automatic wait_reset(input int limit, output bit ok);
		int n;
		n = 0;
		while (reset !== 1'b1 && n < limit) begin
			@(negedge clk);
			if (!reset) begin
				check_value("read in reset", 32'd0, 32'(avm_read));
				check_value("pix_ce in reset", 32'd0, 32'(vga_pix_ce));
				check_value("outputs in reset", IDLE_BITS, out_bits());
			end
			n++;
		end
		ok = reset;
		if (!ok) begin
			errors++;
			$display("Timeout: reset was never released");
		end
	endtask

	task automatic run_frames(input int target, input int limit, output bit ok);
		int start;
		int n;
		start = frames_done;
		n = 0;
		while (frames_done < start + target && n < limit) begin
			run_cycle();
			n++;
		end
		ok = (frames_done >= start + target);
		if (!ok) begin
			errors++;
			$display("Timeout: scan-out did not finish %0d frames in %0d cycles", target, limit);
		end
	endtask

	// bus stalls until a run of pixels goes without data
	task automatic run_starved(input int limit, output bit ok);
		int start;
		int n;
		start = starved;
		stall = 1'b1;
		n = 0;
		while (starved < start + 8 && n < limit) begin
			run_cycle();
			n++;
		end
		stall = 1'b0;
		ok = (starved >= start + 8);
		if (!ok) begin
			errors++;
			$display("Timeout: no pixels went without data while the bus stalled");
		end
	endtask

	initial begin
		bit ok;
		int settled;
		base = BASE;
		avm_waitrequest = 1'b0;
		avm_readdata = '0;
		avm_readdatavalid = 1'b0;
		rng = 32'he598007e;
		last_ret = 0;
		accepted = 0;
		stall = 1'b0;
		cyc = 0;
		delivered = 0;
		consumed = 0;
		starved = 0;
		hpos = 0;
		vpos = 0;
		frames_done = 0;
		last_strobe_cyc = 0;
		seen_strobe = 1'b0;
		exp_underrun = 1'b0;
		held_bits = '0;
		checks = 0;
		errors = 0;

		wait_reset(100, ok);
		// first frame covers the fill after reset
		if (ok) begin
			run_frames(1, FRAME_LIMIT, ok);
		end
		settled = starved;
		if (ok) begin
			run_frames(2, 2 * FRAME_LIMIT, ok);
		end
		if (ok) begin
			check_value("pixels starved while streaming", settled, starved);
			check_value("reads past two frames", 32'd1, 32'(accepted > 2 * FRAME_WORDS));
			run_starved(1000, ok);
		end
		if (ok) begin
			run_frames(1, FRAME_LIMIT, ok);
		end
		settled = starved;
		if (ok) begin
			run_frames(1, FRAME_LIMIT, ok);
		end
		if (ok) begin
			check_value("pixels starved after recovery", settled, starved);
			check_value("underrun after stall", 32'd1, 32'(underrun));
		end

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
vga_pkg.sv
pixel_lane_if.sv
sync_fifo.sv
pixel_lane.sv
frame_fetch.sv
scanout.sv
vga_frame_top.sv
tb_clock.sv
tb_vga_assert.sv
tb_vga_frame.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_vga_frame -f tb.f -o tb_sim \
	&& { sim_out="$(./obj_dir/tb_sim)"; printf '%s\n' "$sim_out"; \
		grep -q "All checks passed" <<< "$sim_out"; } \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
